//--- hdl/displayPkg.sv
package displayPkg;

  // raster geometry, one pixel per clock
  localparam int screenWidth = 320;
  localparam int screenHeight = 240;

  // column needs 9 bits for 0..319
  typedef logic [8:0] pixelXT;

  // row fits in 8 bits for 0..239
  typedef logic [7:0] pixelYT;

  // RGB332 layout as rrr ggg bb
  typedef logic [7:0] colorT;

  // dark blue background
  localparam colorT bgColor = 8'b000_000_10;

  // yellow for the word itself
  localparam colorT textColor = 8'b111_111_00;

  // overlay FSM
  // idle keeps the word hidden and show paints it for a counted number of frames
  typedef enum logic {
    stIdle,
    stShow
  } overlayStateE;

endpackage

//--- hdl/glyphPkg.sv
package glyphPkg;

  // bar orientation
  typedef enum logic {
    segHor,
    segVer
  } segKindE;

  // one beveled bar with offsets relative to the word origin
  typedef struct packed {
    segKindE    kind;
    logic [8:0] xOff;
    logic [7:0] yOff;
    logic [4:0] len;
  } segmentT;

  localparam int segmentCount = 27;

  // full glyph set for BOOM
  // horizontal bars first, then vertical pairs, then the B extras
  localparam segmentT boomSegments [segmentCount] = '{
    // horizontal bars of M, both O and B
    '{segHor, 9'd4,   8'd42, 5'd20},
    '{segHor, 9'd27,  8'd42, 5'd20},
    '{segHor, 9'd60,  8'd0,  5'd20},
    '{segHor, 9'd60,  8'd42, 5'd20},
    '{segHor, 9'd93,  8'd0,  5'd20},
    '{segHor, 9'd93,  8'd42, 5'd20},
    '{segHor, 9'd126, 8'd0,  5'd20},
    '{segHor, 9'd126, 8'd42, 5'd20},
    // vertical bars as upper and lower halves of each column
    '{segVer, 9'd0,   8'd3,  5'd20},
    '{segVer, 9'd0,   8'd24, 5'd20},
    '{segVer, 9'd23,  8'd3,  5'd20},
    '{segVer, 9'd23,  8'd24, 5'd20},
    '{segVer, 9'd46,  8'd3,  5'd20},
    '{segVer, 9'd46,  8'd24, 5'd20},
    '{segVer, 9'd56,  8'd3,  5'd20},
    '{segVer, 9'd56,  8'd24, 5'd20},
    '{segVer, 9'd79,  8'd3,  5'd20},
    '{segVer, 9'd79,  8'd24, 5'd20},
    '{segVer, 9'd89,  8'd3,  5'd20},
    '{segVer, 9'd89,  8'd24, 5'd20},
    '{segVer, 9'd112, 8'd3,  5'd20},
    '{segVer, 9'd112, 8'd24, 5'd20},
    '{segVer, 9'd122, 8'd3,  5'd20},
    '{segVer, 9'd122, 8'd24, 5'd20},
    // shortened right side of the B plus its centre bar
    '{segVer, 9'd137, 8'd24, 5'd17},
    '{segHor, 9'd126, 8'd21, 5'd12},
    '{segVer, 9'd137, 8'd6,  5'd17}
  };

endpackage

//--- hdl/pixelBusIf.sv
`timescale 1ns/1ps

interface pixelBusIf;

  // current scan position
  displayPkg::pixelXT x;
  displayPkg::pixelYT y;

  // high once scanning runs
  logic valid;

  // marks position (0, 0)
  logic frameStart;

  modport source (output x, output y, output valid, output frameStart);

  modport sink (input x, input y, input valid, input frameStart);

endinterface

//--- hdl/pixelScanner.sv
`timescale 1ns/1ps

module pixelScanner (
  input logic clk,
  input logic rstN,
  pixelBusIf.source bus
);

  import displayPkg::*;

  logic lastCol;
  logic lastRow;

  // wrap points of the raster
  assign lastCol = (bus.x == pixelXT'(screenWidth - 1));
  assign lastRow = (bus.y == pixelYT'(screenHeight - 1));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      bus.x <= '0;
      bus.y <= '0;
      bus.valid <= 1'b0;
      bus.frameStart <= 1'b0;
    end else if (!bus.valid) begin
      // first cycle out of reset presents (0, 0)
      bus.valid <= 1'b1;
      bus.frameStart <= 1'b1;
    end else begin
      // x runs fastest, y steps at the end of each line
      if (lastCol) begin
        bus.x <= '0;
        bus.y <= lastRow ? '0 : bus.y + 1'b1;
      end else begin
        bus.x <= bus.x + 1'b1;
      end
      // next position is (0, 0) only after the very last pixel
      bus.frameStart <= lastCol && lastRow;
    end
  end

  // scan stays inside the screen
  assert property (@(posedge clk) disable iff (!rstN)
    bus.valid |-> (int'(bus.x) < screenWidth) && (int'(bus.y) < screenHeight));

endmodule

//--- hdl/boomRenderer.sv
`timescale 1ns/1ps

module boomRenderer #(
  parameter int originX = 82,
  parameter int originY = 96
) (
  input logic clk,
  input logic rstN,
  pixelBusIf.sink bus,
  output logic boomPixel
);

  import glyphPkg::*;

  logic boomDetect;

  // beveled bar test in bar-local terms
  // along runs the length of the bar, across its 5-pixel width
  // inset is 2 on the outer rows, 1 next to them, 0 on the centre row
  function automatic logic barHit(input int along, input int across, input int len);
    int inset;
    if (across < 0 || across > 4) begin
      return 1'b0;
    end
    if (across == 2) begin
      inset = 0;
    end else if (across == 1 || across == 3) begin
      inset = 1;
    end else begin
      inset = 2;
    end
    return (along >= inset) && (along <= len - 1 - inset);
  endfunction

  always_comb begin
    int dx;
    int dy;
    int len;
    boomDetect = 1'b0;
    for (int i = 0; i < segmentCount; i++) begin
      // position relative to this bar's corner
      dx = int'(bus.x) - (originX + int'(boomSegments[i].xOff));
      dy = int'(bus.y) - (originY + int'(boomSegments[i].yOff));
      len = int'(boomSegments[i].len);
      // vertical bars are the same shape with axes swapped
      if (boomSegments[i].kind == segHor) begin
        if (barHit(dx, dy, len)) begin
          boomDetect = 1'b1;
        end
      end else begin
        if (barHit(dy, dx, len)) begin
          boomDetect = 1'b1;
        end
      end
    end
  end

  // registered hit masked by valid
  always_ff @(posedge clk) begin
    if (!rstN) begin
      boomPixel <= 1'b0;
    end else begin
      boomPixel <= bus.valid && boomDetect;
    end
  end

  // no hit can come out of a non-scanning cycle
  assert property (@(posedge clk) disable iff (!rstN)
    !bus.valid |=> !boomPixel);

endmodule

//--- hdl/boomOverlay.sv
`timescale 1ns/1ps

module boomOverlay #(
  parameter int showFrames = 2
) (
  input logic clk,
  input logic rstN,
  input logic boomTrigger,
  pixelBusIf.sink bus,
  input logic boomPixel,
  output displayPkg::pixelXT pixelX,
  output displayPkg::pixelYT pixelY,
  output logic pixelValid,
  output logic frameStart,
  output displayPkg::colorT pixelColor
);

  import displayPkg::*;

  localparam int countW = $clog2(showFrames + 1);

  overlayStateE state;
  logic pending;
  logic [countW-1:0] frameCount;
  logic busFrame;

  // two-stage alignment where stage 1 lines up with boomPixel
  pixelXT xDly [2];
  pixelYT yDly [2];
  logic [1:0] validDly;
  logic [1:0] startDly;

  assign busFrame = bus.valid && bus.frameStart;

  // trigger latch and frame counting FSM
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= stIdle;
      pending <= 1'b0;
      frameCount <= '0;
    end else begin
      if (busFrame) begin
        if (pending) begin
          // (re)start the show window at this frame
          state <= stShow;
          frameCount <= countW'(showFrames);
        end else if (state == stShow) begin
          if (frameCount == countW'(1)) begin
            state <= stIdle;
          end
          frameCount <= frameCount - 1'b1;
        end
        // pulse on the boundary cycle waits for the next frame
        pending <= boomTrigger;
      end else if (boomTrigger) begin
        pending <= 1'b1;
      end
    end
  end

  // coordinate delay line
  always_ff @(posedge clk) begin
    xDly[0] <= bus.x;
    yDly[0] <= bus.y;
    xDly[1] <= xDly[0];
    yDly[1] <= yDly[0];
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validDly <= '0;
      startDly <= '0;
      pixelColor <= bgColor;
    end else begin
      validDly <= {validDly[0], bus.valid};
      startDly <= {startDly[0], bus.frameStart};
      // state here already reflects the frame of the stage-1 pixel
      pixelColor <= (state == stShow && boomPixel) ? textColor : bgColor;
    end
  end

  assign pixelX = xDly[1];
  assign pixelY = yDly[1];
  assign pixelValid = validDly[1];
  assign frameStart = startDly[1];

  // count bounded by the window and cleared when hidden
  assert property (@(posedge clk) disable iff (!rstN)
    (int'(frameCount) <= showFrames) && ((state == stIdle) -> (frameCount == '0)));

endmodule

//--- hdl/boomDisplay.sv
`timescale 1ns/1ps

module boomDisplay #(
  parameter int originX = 82,
  parameter int originY = 96,
  parameter int showFrames = 2
) (
  input logic clk,
  input logic rstN,
  input logic boomTrigger,
  output displayPkg::pixelXT pixelX,
  output displayPkg::pixelYT pixelY,
  output logic pixelValid,
  output logic frameStart,
  output displayPkg::colorT pixelColor
);

  // raster position shared by all three stages
  pixelBusIf bus0 ();

  // renderer hit, one cycle behind the bus
  logic boomPixel;

  pixelScanner scanner0 (
    .clk  (clk),
    .rstN (rstN),
    .bus  (bus0.source)
  );

  boomRenderer #(
    .originX (originX),
    .originY (originY)
  ) renderer0 (
    .clk       (clk),
    .rstN      (rstN),
    .bus       (bus0.sink),
    .boomPixel (boomPixel)
  );

  boomOverlay #(
    .showFrames (showFrames)
  ) overlay0 (
    .clk         (clk),
    .rstN        (rstN),
    .boomTrigger (boomTrigger),
    .bus         (bus0.sink),
    .boomPixel   (boomPixel),
    .pixelX      (pixelX),
    .pixelY      (pixelY),
    .pixelValid  (pixelValid),
    .frameStart  (frameStart),
    .pixelColor  (pixelColor)
  );

endmodule

//--- sim/boomDisplayTb.sv
`timescale 1ns/1ps

module boomDisplayTb;

  localparam int framePixels = 76800;
  localparam int maxLines = 32;

  logic clk;
  logic rstN;
  logic boomTrigger;
  displayPkg::pixelXT pixelX;
  displayPkg::pixelYT pixelY;
  logic pixelValid;
  logic frameStart;
  displayPkg::colorT pixelColor;

  // five hex words per golden line
  logic [15:0] golden [maxLines*5];
  int targetIdx [maxLines];
  bit matched [maxLines];
  int lineCount;
  int maxFrame;
  // output frame number and expected raster index of the next valid pixel
  int frameNum;
  int pixIdx;
  bit validSeen;
  int valueErrors;
  int otherErrors;
  int cycleLimit;
  int cycles;

  boomDisplay dut0 (
    .clk         (clk),
    .rstN        (rstN),
    .boomTrigger (boomTrigger),
    .pixelX      (pixelX),
    .pixelY      (pixelY),
    .pixelValid  (pixelValid),
    .frameStart  (frameStart),
    .pixelColor  (pixelColor)
  );

  always #50 clk = ~clk;

  function automatic int goldenField(input int line, input int col);
    return int'(golden[line*5+col]);
  endfunction

  task automatic finishRun();
    $display("value errors %0d, other errors %0d", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // one valid output pixel against raster order and the golden lines
  task automatic samplePixel();
    int expX;
    int expY;
    expX = pixIdx % 320;
    expY = pixIdx / 320;
    if (frameStart) begin
      frameNum++;
    end
    assert (int'(pixelX) == expX && int'(pixelY) == expY) else begin
      $display("FAIL pixelX/pixelY: got %h/%h expected %h/%h",
        pixelX, pixelY, expX[8:0], expY[7:0]);
      valueErrors++;
    end
    assert (frameStart == (pixIdx == 0)) else begin
      $display("FAIL frameStart: got %h expected %h", frameStart, pixIdx == 0);
      valueErrors++;
    end
    // pulse holds until the next falling edge, so one rising edge sees it
    boomTrigger = 1'b0;
    for (int i = 0; i < lineCount; i++) begin
      if (goldenField(i, 1) == frameNum) begin
        if (goldenField(i, 0) == 0 && targetIdx[i] == pixIdx) begin
          boomTrigger = 1'b1;
        end
        if (goldenField(i, 0) == 1 && goldenField(i, 2) == expX && goldenField(i, 3) == expY) begin
          matched[i] = 1'b1;
          assert (pixelColor == golden[i*5+4][7:0]) else begin
            $display("FAIL pixelColor at frame %0d (%0d, %0d): got %h expected %h",
              frameNum, expX, expY, pixelColor, golden[i*5+4][7:0]);
            valueErrors++;
          end
        end
      end
    end
    pixIdx = (pixIdx == framePixels - 1) ? 0 : pixIdx + 1;
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    boomTrigger = 1'b0;
    frameNum = -1;
    pixIdx = 0;
    validSeen = 1'b0;
    valueErrors = 0;
    otherErrors = 0;
    void'($urandom(35511));
    // unused words stay all ones, which ends the line list
    for (int i = 0; i < maxLines * 5; i++) begin
      golden[i] = 16'hffff;
    end
    $readmemh("sim/boomGolden.txt", golden);
    lineCount = 0;
    maxFrame = 0;
    while (lineCount < maxLines && golden[lineCount*5] != 16'hffff) begin
      if (goldenField(lineCount, 1) > maxFrame) begin
        maxFrame = goldenField(lineCount, 1);
      end
      // trigger pixel kept away from frame edges so scanner and output agree on the frame
      targetIdx[lineCount] = 16 + int'($urandom % (framePixels - 32));
      matched[lineCount] = 1'b0;
      lineCount++;
    end
    cycleLimit = (maxFrame + 2) * framePixels + 100;
    repeat (8) begin
      @(negedge clk);
      assert (!pixelValid) else begin
        $display("pixelValid went high while reset was held");
        otherErrors++;
      end
    end
    rstN = 1'b1;
    // run until the first pixel after the last golden frame
    while (frameNum <= maxFrame) begin
      @(negedge clk);
      if (pixelValid) begin
        validSeen = 1'b1;
        samplePixel();
      end else begin
        assert (!validSeen) else begin
          $display("pixelValid dropped in the middle of the scan");
          otherErrors++;
        end
      end
    end
    for (int i = 0; i < lineCount; i++) begin
      if (goldenField(i, 0) == 1) begin
        assert (matched[i]) else begin
          $display("golden check line %0d never matched an output pixel", i);
          otherErrors++;
        end
      end
    end
    finishRun();
  end

  // watchdog on the rising clock
  initial begin
    cycles = 0;
    @(posedge clk);
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles without reaching the end of the frames", cycles);
    otherErrors++;
    finishRun();
  end

endmodule

//--- boomDisplay.f
hdl/displayPkg.sv
hdl/glyphPkg.sv
hdl/pixelBusIf.sv
hdl/pixelScanner.sv
hdl/boomRenderer.sv
hdl/boomOverlay.sv
hdl/boomDisplay.sv
sim/boomDisplayTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := boomDisplayTb
FILELIST  := boomDisplay.f
OBJDIR    := obj_dir
LOG       := sim.log

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- sim/boomGolden.txt
// columns are kind, frame, x, y and color in hex
// kind 0 pulses boomTrigger in that frame and kind 1 checks the color at (x, y)
0 1 0 0 0
0 5 0 0 0
0 6 0 0 0
1 0 54 63 02
1 2 90 60 fc
1 2 8f 60 02
1 2 53 64 fc
1 2 53 63 02
1 3 dd 78 fc
1 3 dd 89 02
1 3 db 77 fc
1 3 dc 77 02
1 3 dd 76 fc
1 3 dd 65 02
1 4 90 60 02
1 4 dd 78 02
1 6 90 60 fc
1 8 90 60 fc
1 9 90 60 02
